//--- hw/rv_exec_defs.svh
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// Datapath and register file size, fixed by RV32I
`define XLEN                32          // Data width
`define NUM_REGS            32          // Architectural registers x0..x31

// Major opcodes, instr[6:0]
`define OPCODE_OP           7'b0110011  // Register-register ALU
`define OPCODE_OP_IMM       7'b0010011  // Register-immediate ALU

// ALU operation codes, instr[14:12]
`define FUNCT3_ADD_SUB      3'b000      // ADD / SUB / ADDI
`define FUNCT3_SLL          3'b001      // Shift left logical
`define FUNCT3_SLT          3'b010      // Signed compare
`define FUNCT3_SLTU         3'b011      // Unsigned compare
`define FUNCT3_XOR          3'b100      // Bitwise XOR
`define FUNCT3_SRL_SRA      3'b101      // Shift right, logical or arithmetic
`define FUNCT3_OR           3'b110      // Bitwise OR
`define FUNCT3_AND          3'b111      // Bitwise AND

// funct7 codes, instr[31:25]
`define FUNCT7_BASE         7'b0000000  // Base operation
`define FUNCT7_SUB_SRA      7'b0100000  // Alternate operation (SUB, SRA)

// Instruction field positions
`define INSTR_OPCODE        6:0         // Major opcode
`define INSTR_RD            11:7        // Destination register
`define INSTR_FUNCT3        14:12       // Operation code
`define INSTR_RS1           19:15       // First source register
`define INSTR_RS2           24:20       // Second source register
`define INSTR_FUNCT7        31:25       // Operation modifier
`define INSTR_IMM_I         31:20       // I-type immediate

`endif

//--- hw/rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_defs.svh"

package rv_exec_pkg;

    // Operand and result of the datapath
    typedef logic [`XLEN-1:0] word_t;

    // Raw 32-bit instruction word
    typedef logic [31:0] instr_t;

    // Register index, x0..x31
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    typedef logic [2:0] funct3_t;      // Operation code field
    typedef logic [6:0] funct7_t;      // Operation modifier field

    // Shift amount, low bits of the second operand
    typedef logic [$clog2(`XLEN)-1:0] shamt_t;

endpackage : rv_exec_pkg

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module alu
    import rv_exec_pkg::*;
(
    input  funct3_t funct3,            // Operation code
    input  funct7_t funct7,            // Operation modifier
    input  logic    alu_en,            // Valid legal instruction
    input  logic    src_sel,           // 1 selects rs2, 0 selects immediate
    input  word_t   reg_data_1,        // rs1 value
    input  word_t   reg_data_2,        // rs2 value
    input  word_t   immediate,         // Sign-extended I-type immediate
    output word_t   alu_res            // Operation result
);

    word_t  op_a;                      // First operand
    word_t  op_b;                      // Second operand after mux
    shamt_t shamt;                     // Shift amount
    logic   alt_op;                    // funct7 asks for the alternate operation
    logic   do_sub;                    // Subtract instead of add
    logic   do_sra;                    // Arithmetic instead of logical right shift

    assign op_a  = reg_data_1;
    assign op_b  = src_sel ? reg_data_2 : immediate;   // Register or immediate form
    assign shamt = op_b[$bits(shamt_t)-1:0];           // Only low 5 bits count

    assign alt_op = (funct7 == `FUNCT7_SUB_SRA);
    assign do_sub = alt_op && src_sel;  // SUB exists in register form only
    assign do_sra = alt_op;             // SRA and SRAI both

    always_comb begin
        alu_res = '0;                   // Idle or illegal gives zero
        if (alu_en) begin
            case (funct3)
                `FUNCT3_ADD_SUB: begin
                    if (do_sub) begin
                        alu_res = op_a - op_b;                 // SUB
                    end else begin
                        alu_res = op_a + op_b;                 // ADD / ADDI
                    end
                end
                `FUNCT3_SLL: begin
                    alu_res = op_a << shamt;                   // Zero fill
                end
                `FUNCT3_SLT: begin
                    alu_res = word_t'($signed(op_a) < $signed(op_b));
                end
                `FUNCT3_SLTU: begin
                    alu_res = word_t'(op_a < op_b);            // Unsigned compare
                end
                `FUNCT3_XOR: begin
                    alu_res = op_a ^ op_b;
                end
                `FUNCT3_SRL_SRA: begin
                    if (do_sra) begin
                        alu_res = word_t'($signed(op_a) >>> shamt);  // Sign fill
                    end else begin
                        alu_res = op_a >> shamt;               // Zero fill
                    end
                end
                `FUNCT3_OR: begin
                    alu_res = op_a | op_b;
                end
                `FUNCT3_AND: begin
                    alu_res = op_a & op_b;
                end
                default: begin
                    alu_res = '0;
                end
            endcase
        end
    end

endmodule : alu

`default_nettype wire

//--- hw/alu_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module alu_decoder
    import rv_exec_pkg::*;
(
    input  logic     instr_valid,      // Instruction present this cycle
    input  instr_t   instr,            // Raw instruction word
    output reg_idx_t rs1,              // First source index
    output reg_idx_t rs2,              // Second source index
    output reg_idx_t rd,               // Destination index
    output funct3_t  funct3,           // Operation code to ALU
    output funct7_t  funct7,           // Operation modifier to ALU
    output logic     src_sel,          // 1 for OP, 0 for OP-IMM
    output word_t    immediate,        // Sign-extended I-type immediate
    output logic     legal,            // Supported encoding
    output logic     alu_en            // Valid and legal
);

    logic [6:0] opcode;                // Major opcode
    funct7_t    funct7_raw;            // instr[31:25] as encoded
    logic       is_op;                 // Register-register form
    logic       is_op_imm;             // Register-immediate form
    logic       is_shift;              // SLL or SRL/SRA code
    logic       funct7_ok;             // funct7 fits the operation
    logic       alt_allowed;           // Operation has an alternate form

    // Field extraction
    assign opcode     = instr[`INSTR_OPCODE];
    assign rd         = instr[`INSTR_RD];
    assign funct3     = instr[`INSTR_FUNCT3];
    assign rs1        = instr[`INSTR_RS1];
    assign rs2        = instr[`INSTR_RS2];
    assign funct7_raw = instr[`INSTR_FUNCT7];

    // 12-bit immediate, sign bit is instr[31]
    assign immediate = {{(`XLEN-12){instr[31]}}, instr[`INSTR_IMM_I]};

    assign is_op     = (opcode == `OPCODE_OP);
    assign is_op_imm = (opcode == `OPCODE_OP_IMM);
    assign is_shift  = (funct3 == `FUNCT3_SLL) || (funct3 == `FUNCT3_SRL_SRA);

    assign src_sel = is_op;            // OP reads rs2, OP-IMM uses immediate

    // SUB_SRA valid only for ADD/SUB in OP and for right shifts
    always_comb begin
        alt_allowed = 1'b0;
        if (funct3 == `FUNCT3_SRL_SRA) begin
            alt_allowed = 1'b1;                        // SRA / SRAI
        end else if (funct3 == `FUNCT3_ADD_SUB) begin
            alt_allowed = is_op;                       // No SUBI
        end
    end

    always_comb begin
        funct7_ok = 1'b0;
        if (is_op || (is_op_imm && is_shift)) begin
            funct7_ok = (funct7_raw == `FUNCT7_BASE) ||
                        ((funct7_raw == `FUNCT7_SUB_SRA) && alt_allowed);
        end else if (is_op_imm) begin
            funct7_ok = 1'b1;          // Upper bits are immediate here
        end
    end

    assign legal = (is_op || is_op_imm) && funct7_ok;

    // Immediate bit 30 must not pick an alternate op
    assign funct7 = (is_op_imm && !is_shift) ? `FUNCT7_BASE : funct7_raw;

    assign alu_en = instr_valid && legal;

endmodule : alu_decoder

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module reg_file
    import rv_exec_pkg::*;
(
    input  logic     clk,              // Core clock
    input  logic     arst_n,           // Async reset, active low
    input  reg_idx_t rs1,              // Read port 1 index
    input  reg_idx_t rs2,              // Read port 2 index
    input  logic     wr_en,            // Write strobe, never set for x0
    input  reg_idx_t wr_idx,           // Write index
    input  word_t    wr_data,          // Write data
    output word_t    rd_data_1,        // Read port 1 data
    output word_t    rd_data_2         // Read port 2 data
);

    word_t regs [1:`NUM_REGS-1];       // x1..x31, x0 is not stored

    // Written at the edge, visible to the next instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;         // All registers read zero after reset
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Combinational reads with x0 hardwired
    assign rd_data_1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd_data_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule : reg_file

`default_nettype wire

//--- hw/writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_stage
    import rv_exec_pkg::*;
(
    input  logic     clk,              // Core clock
    input  logic     arst_n,           // Async reset, active low
    input  logic     instr_valid,      // Instruction present this cycle
    input  logic     legal,            // Decoder accepted the encoding
    input  reg_idx_t rd,               // Destination index
    input  word_t    alu_res,          // ALU result
    output logic     wr_en,            // Register file write strobe
    output reg_idx_t wr_idx,           // Register file write index
    output word_t    wr_data,          // Register file write data
    output logic     wb_valid,         // Writeback pulse, one cycle
    output reg_idx_t wb_rd,            // Reported destination
    output word_t    wb_data,          // Reported result
    output logic     illegal           // Illegal pulse, one cycle
);

    logic accept;                      // Legal instruction this cycle

    assign accept = instr_valid && legal;

    // Same-edge write so the next instruction sees the result
    assign wr_en   = accept && (rd != '0);   // x0 writes are dropped
    assign wr_idx  = rd;
    assign wr_data = alu_res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
            wb_data  <= '0;
            illegal  <= 1'b0;
        end else begin
            wb_valid <= accept;                    // Pulse for one cycle
            illegal  <= instr_valid && !legal;     // Rejected encoding
            if (accept) begin
                wb_rd   <= rd;                     // Held between pulses
                wb_data <= alu_res;                // Reported even for x0
            end
        end
    end

endmodule : writeback_stage

`default_nettype wire

//--- hw/rv_exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_unit
    import rv_exec_pkg::*;
(
    input  logic     clk,              // Core clock
    input  logic     arst_n,           // Async reset, active low
    input  logic     instr_valid,      // Instruction level, sampled each edge
    input  instr_t   instr,            // Instruction word
    output logic     wb_valid,         // Result pulse, one cycle after issue
    output reg_idx_t wb_rd,            // Result destination
    output word_t    wb_data,          // Result value
    output logic     illegal           // Rejected instruction pulse
);

    reg_idx_t rs1;                     // Source index 1
    reg_idx_t rs2;                     // Source index 2
    reg_idx_t rd;                      // Destination index
    funct3_t  funct3;                  // Operation code
    funct7_t  funct7;                  // Filtered modifier
    logic     src_sel;                 // Operand B select
    word_t    immediate;               // I-type immediate
    logic     legal;                   // Encoding accepted
    logic     alu_en;                  // ALU active
    word_t    reg_data_1;              // rs1 value
    word_t    reg_data_2;              // rs2 value
    word_t    alu_res;                 // ALU output
    logic     wr_en;                   // Register write strobe
    reg_idx_t wr_idx;                  // Register write index
    word_t    wr_data;                 // Register write data

    alu_decoder alu_decoder_i (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .funct3      (funct3),
        .funct7      (funct7),
        .src_sel     (src_sel),
        .immediate   (immediate),
        .legal       (legal),
        .alu_en      (alu_en)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .rd_data_1 (reg_data_1),
        .rd_data_2 (reg_data_2)
    );

    alu alu_i (
        .funct3     (funct3),
        .funct7     (funct7),
        .alu_en     (alu_en),
        .src_sel    (src_sel),
        .reg_data_1 (reg_data_1),
        .reg_data_2 (reg_data_2),
        .immediate  (immediate),
        .alu_res    (alu_res)
    );

    writeback_stage writeback_stage_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .legal       (legal),
        .rd          (rd),
        .alu_res     (alu_res),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

endmodule : rv_exec_unit

`default_nettype wire

//--- verification/rv_exec_unit_properties.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_unit_properties (
    input logic clk,                   // Core clock
    input logic arst_n,                // Async reset, active low
    input logic instr_valid,           // Issue level
    input logic wb_valid,              // Writeback pulse
    input logic illegal                // Illegal pulse
);

    // One outcome per cycle at most
    a_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(wb_valid && illegal))
        else $error("wb_valid and illegal are high together");

    // Every issue answered one cycle later
    a_answered: assert property (@(posedge clk) disable iff (!arst_n)
        $past(instr_valid) |-> (wb_valid || illegal))
        else $error("issued instruction got neither wb_valid nor illegal");

    a_no_spurious: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_valid || illegal) |-> $past(instr_valid))
        else $error("pulse without a preceding instr_valid");

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!wb_valid && !illegal))
        else $error("pulse while reset is asserted");

endmodule : rv_exec_unit_properties

bind rv_exec_unit rv_exec_unit_properties props_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .illegal     (illegal)
);

`default_nettype wire

//--- verification/rv_exec_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module rv_exec_unit_tb
    import rv_exec_pkg::*;
;

    // Operation codes of the reference model
    localparam int OP_ADD  = 0;
    localparam int OP_SUB  = 1;
    localparam int OP_SLL  = 2;
    localparam int OP_SLT  = 3;
    localparam int OP_SLTU = 4;
    localparam int OP_XOR  = 5;
    localparam int OP_SRL  = 6;
    localparam int OP_SRA  = 7;
    localparam int OP_OR   = 8;
    localparam int OP_AND  = 9;

    string op_name [10] = '{"ADD", "SUB", "SLL", "SLT", "SLTU",
                            "XOR", "SRL", "SRA", "OR", "AND"};

    logic     clk;
    logic     arst_n;
    logic     instr_valid;
    instr_t   instr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     illegal;

    word_t  shadow [32];               // Register model, x0 never written
    integer seed;                      // $random state
    int     checks;
    int     mismatches;
    int     missing;                   // Absent pulses
    int     n_issued;                  // Instructions sent, sizes the watchdog
    int     cycles;

    rv_exec_unit dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;         // 10 ns period
    end

    // Run limit grows with every issued instruction
    initial begin : watchdog
        cycles = 0;
        while (cycles < 50 * n_issued + 1000) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: watchdog expired after %0d cycles, tests did not finish", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic funct3_t f3_of(input int op);
        case (op)
            OP_ADD, OP_SUB: return `FUNCT3_ADD_SUB;
            OP_SLL:         return `FUNCT3_SLL;
            OP_SLT:         return `FUNCT3_SLT;
            OP_SLTU:        return `FUNCT3_SLTU;
            OP_XOR:         return `FUNCT3_XOR;
            OP_SRL, OP_SRA: return `FUNCT3_SRL_SRA;
            OP_OR:          return `FUNCT3_OR;
            default:        return `FUNCT3_AND;
        endcase
    endfunction

    // RV32I semantics, shifts use b[4:0] only
    function automatic word_t calc(input int op, input word_t a, input word_t b);
        shamt_t sh;
        sh = b[4:0];
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_SLL:  return a << sh;
            OP_SLT:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};  // Signs differ
            OP_SLTU: return {31'b0, (a < b)};
            OP_XOR:  return a ^ b;
            OP_SRL:  return a >> sh;
            OP_SRA:  return a[31] ? ~(~a >> sh) : a >> sh;   // Sign fill
            OP_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %08h expected %08h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got x%0d expected x%0d", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0b expected %0b", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    // Called at a falling edge, returns at the next one so issues can chain
    task automatic exec_instr(input instr_t word, input bit exp_legal, input reg_idx_t exp_rd,
                              input word_t exp_data, input string what);
        instr_valid = 1'b1;
        instr       = word;
        n_issued++;
        @(negedge clk);
        instr_valid = 1'b0;
        if (exp_legal) begin
            if (exp_rd != 5'd0)
                shadow[exp_rd] = exp_data;      // Architectural state, x0 stays zero
            if (!wb_valid) begin
                $display("ERROR at %0t: no writeback pulse after %s", $time, what);
                missing++;
            end else begin
                check_idx(wb_rd, exp_rd, {what, " wb_rd"});
                check_word(wb_data, exp_data, {what, " wb_data"});
            end
            check_flag(illegal, 1'b0, {what, " illegal"});
        end else begin
            if (!illegal) begin
                $display("ERROR at %0t: no illegal pulse after %s", $time, what);
                missing++;
            end
            check_flag(wb_valid, 1'b0, {what, " wb_valid"});
        end
    endtask

    task automatic reg_op(input int op, input reg_idx_t rd, input reg_idx_t rs1,
                          input reg_idx_t rs2);
        funct7_t f7;
        f7 = (op == OP_SUB || op == OP_SRA) ? `FUNCT7_SUB_SRA : `FUNCT7_BASE;
        exec_instr({f7, rs2, rs1, f3_of(op), rd, `OPCODE_OP}, 1'b1, rd,
                   calc(op, shadow[rs1], shadow[rs2]), op_name[op]);
    endtask

    task automatic imm_op(input int op, input reg_idx_t rd, input reg_idx_t rs1,
                          input logic [11:0] imm);
        logic [11:0] field;
        word_t       imm_ext;
        field = imm;
        if (op == OP_SLL || op == OP_SRL)
            field = {`FUNCT7_BASE, imm[4:0]};        // shamt only
        if (op == OP_SRA)
            field = {`FUNCT7_SUB_SRA, imm[4:0]};
        imm_ext = {{20{field[11]}}, field};
        exec_instr({field, rs1, f3_of(op), rd, `OPCODE_OP_IMM}, 1'b1, rd,
                   calc(op, shadow[rs1], imm_ext), {op_name[op], "I"});
    endtask

    // 11 + 11 + 10 bits assembled with positive immediates
    task automatic load_reg(input reg_idx_t rd, input word_t v);
        imm_op(OP_ADD, rd, 5'd0, {1'b0, v[31:21]});
        imm_op(OP_SLL, rd, rd, 12'd11);
        imm_op(OP_OR, rd, rd, {1'b0, v[20:10]});
        imm_op(OP_SLL, rd, rd, 12'd10);
        imm_op(OP_OR, rd, rd, {2'b0, v[9:0]});
    endtask

    task automatic reg_form_ops();
        int ops [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU};
        for (int r = 1; r <= 6; r++)
            load_reg(reg_idx_t'(r), $random(seed));
        load_reg(5'd7, 32'h8000_0000 | $random(seed));   // Negative
        load_reg(5'd8, 32'h7fff_ffff);
        for (int p = 0; p < 4; p++)
            for (int j = 0; j < 7; j++)
                reg_op(ops[j], reg_idx_t'(9 + j), reg_idx_t'(1 + 2 * p), reg_idx_t'(2 + 2 * p));
    endtask

    task automatic imm_form_ops();
        int          ops [6]  = '{OP_ADD, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU};
        logic [11:0] imms [6] = '{12'h7ff, 12'h800, 12'hfff, 12'h001, 12'hc35, 12'h000};
        word_t       rnd;
        for (int r = 1; r <= 8; r += 2)
            for (int j = 0; j < 6; j++) begin
                imm_op(ops[j], reg_idx_t'(16 + j), reg_idx_t'(r), imms[j]);
                rnd = $random(seed);
                imm_op(ops[j], 5'd22, reg_idx_t'(r), rnd[11:0]);
            end
        imm_op(OP_ADD, 5'd23, 5'd3, 12'h415);   // Bit 30 set, still ADDI
        imm_op(OP_ADD, 5'd23, 5'd7, 12'hc00);
    endtask

    task automatic shift_ops();
        word_t rnd;
        for (int k = 0; k < 6; k++) begin
            load_reg(5'd24, $random(seed));     // Upper bits must be ignored
            reg_op(OP_SLL, 5'd26, 5'd7, 5'd24);
            reg_op(OP_SRL, 5'd27, 5'd7, 5'd24);
            reg_op(OP_SRA, 5'd28, 5'd7, 5'd24);
            reg_op(OP_SRA, 5'd28, 5'd1, 5'd24);
            rnd = $random(seed);
            imm_op(OP_SLL, 5'd29, 5'd2, rnd[11:0]);
            imm_op(OP_SRL, 5'd30, 5'd7, rnd[11:0]);
            imm_op(OP_SRA, 5'd31, 5'd7, rnd[11:0]);
        end
        imm_op(OP_SRA, 5'd31, 5'd7, 12'd31);    // All sign bits
        imm_op(OP_SRL, 5'd30, 5'd7, 12'd31);
        imm_op(OP_SLL, 5'd29, 5'd7, 12'd0);
    endtask

    task automatic dependent_chain();
        imm_op(OP_ADD, 5'd1, 5'd0, 12'h005);
        reg_op(OP_ADD, 5'd2, 5'd1, 5'd1);
        reg_op(OP_SUB, 5'd3, 5'd2, 5'd1);
        reg_op(OP_SLL, 5'd4, 5'd3, 5'd2);
        imm_op(OP_XOR, 5'd4, 5'd4, 12'hfff);
        reg_op(OP_SRA, 5'd5, 5'd4, 5'd1);
        imm_op(OP_ADD, 5'd0, 5'd5, 12'h04d);    // Pulses, x0 stays zero
        reg_op(OP_OR, 5'd6, 5'd0, 5'd0);
        reg_op(OP_ADD, 5'd6, 5'd0, 5'd5);
    endtask

    task automatic illegal_encodings();
        exec_instr({7'b0000000, 5'd2, 5'd1, 3'b000, 5'd12, 7'b0110111}, 1'b0, 5'd0, '0,
                   "LUI opcode");
        exec_instr({`FUNCT7_SUB_SRA, 5'd2, 5'd1, `FUNCT3_AND, 5'd12, `OPCODE_OP}, 1'b0, 5'd0,
                   '0, "AND with SUB_SRA");
        reg_op(OP_ADD, 5'd13, 5'd1, 5'd2);
        exec_instr({7'b0000001, 5'd2, 5'd1, `FUNCT3_ADD_SUB, 5'd12, `OPCODE_OP}, 1'b0, 5'd0,
                   '0, "ADD with funct7 0000001");
        exec_instr({`FUNCT7_SUB_SRA, 5'd3, 5'd1, `FUNCT3_SLL, 5'd12, `OPCODE_OP_IMM}, 1'b0,
                   5'd0, '0, "SLLI with SUB_SRA");
        exec_instr({7'b0000001, 5'd3, 5'd1, `FUNCT3_SRL_SRA, 5'd12, `OPCODE_OP_IMM}, 1'b0,
                   5'd0, '0, "SRLI with funct7 0000001");
        imm_op(OP_ADD, 5'd14, 5'd12, 12'h000);  // x12 untouched
    endtask

    initial begin
        seed        = 32'hde55_13b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        checks      = 0;
        mismatches  = 0;
        missing     = 0;
        n_issued    = 0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_flag(wb_valid, 1'b0, "wb_valid after reset");
        check_flag(illegal, 1'b0, "illegal after reset");
        check_idx(wb_rd, 5'd0, "wb_rd after reset");
        check_word(wb_data, '0, "wb_data after reset");
        reg_op(OP_OR, 5'd9, 5'd17, 5'd31);      // Cleared registers read zero
        reg_form_ops();
        imm_form_ops();
        shift_ops();
        dependent_chain();
        illegal_encodings();
        @(negedge clk);
        $display("checks %0d, mismatches %0d, missing pulses %0d, instructions %0d",
                 checks, mismatches, missing, n_issued);
        if (mismatches == 0 && missing == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : rv_exec_unit_tb

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/rv_exec_pkg.sv
hw/alu.sv
hw/alu_decoder.sv
hw/reg_file.sv
hw/writeback_stage.sv
hw/rv_exec_unit.sv
verification/rv_exec_unit_properties.sv
verification/rv_exec_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the execute unit testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

TOP=rv_exec_unit_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
